//--- arch_state.sv
`timescale 1ns/100ps
`default_nettype none

module arch_state import uop_pkg::*; #(
   parameter logic [31:0] RESET_EIP = 32'h0000_0000
) (
   input  wire         CLK,
   input  wire         rst_n,
   input  wire  [2:0]  gpr_ra,
   input  wire  [2:0]  gpr_rb,
   output logic [31:0] rd_a,
   output logic [31:0] rd_b,
   input  wire         gpr_ld,
   input  wire  [2:0]  gpr_dr,
   input  wire  [31:0] gpr_data,
   input  wire         flags_ld,
   input  wire  [1:0]  flags_data,
   output logic [1:0]  cur_flags,
   input  wire         eip_ld,
   input  wire  [31:0] eip_data,
   input  wire         halt_ld,
   input  wire         stall,
   output logic [31:0] fetch_eip,
   output logic        halted
);

   logic [31:0] gpr [8];
   logic [1:0]  flags_q;
   logic [31:0] eip_q;
   core_state_e state_q;

   assign rd_a      = gpr[gpr_ra];
   assign rd_b      = gpr[gpr_rb];
   assign cur_flags = flags_q;
   assign fetch_eip = eip_q;
   assign halted    = (state_q == st_halted);

   // register file and flags
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            gpr[i] <= '0;
         end
         flags_q <= '0;
      end else begin
         if (gpr_ld)
            gpr[gpr_dr] <= gpr_data;
         if (flags_ld)
            flags_q <= flags_data;
      end
   end

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         eip_q   <= RESET_EIP;
         state_q <= st_run;
      end else begin
         if (halt_ld)
            state_q <= st_halted;
         // redirect wins over sequential advance
         if (eip_ld)
            eip_q <= eip_data;
         else if (!stall && !halt_ld && state_q == st_run)
            eip_q <= eip_q + 32'd1;
      end
   end

endmodule

`default_nettype wire

//--- flist.f
uop_pkg.sv
arch_state.sv
uop_decode.sv
uop_execute.sv
writeback.sv
uop_core.sv
tb_uop_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f flist.f --top-module tb_uop_core \
   -o sim_uop_core &&
./obj_dir/sim_uop_core | grep -F "Finished with no errors" ||
{ echo "simulation failed"; exit 1; }

//--- tb_uop_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_uop_core import uop_pkg::*; ();

   localparam int ROM_DEPTH = 64;
   localparam int TIMEOUT   = 4000;
   localparam logic [31:0] HALT_WORD = {op_halt, 28'd0};

   logic        CLK = 1'b0;
   logic        rst_n;
   logic [31:0] instr;
   logic        write_ready = 1'b1;
   wire  [31:0] fetch_eip;
   wire         dcache_write;
   wire  [31:0] dcache_addr;
   wire  [31:0] dcache_data;
   wire         halted;

   logic [31:0] rom [ROM_DEPTH];
   logic [5:0]  prog_pc;
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   integer      seed;
   logic        ready_pat [256];
   logic [7:0]  pat_idx = 8'd0;
   logic        bp_mode = 1'b0;
   int          got_n = 0;
   logic        hold_pending = 1'b0;
   logic [31:0] hold_addr;
   logic [31:0] hold_data;

   uop_core #(
      .RESET_EIP (32'h0000_0000)
   ) uop_core_inst (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .fetch_eip    (fetch_eip),
      .instr        (instr),
      .dcache_write (dcache_write),
      .dcache_addr  (dcache_addr),
      .dcache_data  (dcache_data),
      .write_ready  (write_ready),
      .halted       (halted)
   );

   always #10 CLK = ~CLK;

   // fetch past the end of the ROM sees halt
   assign instr = (fetch_eip < ROM_DEPTH) ? rom[fetch_eip[5:0]] : HALT_WORD;

   always @(posedge CLK) begin
      if (bp_mode)
         write_ready <= ready_pat[pat_idx];
      else
         write_ready <= 1'b1;
      pat_idx <= pat_idx + 8'd1;
   end

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1);
   endtask

   task automatic check_store(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         stop_on_error($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic check_state(input string name, input core_state_e got, input core_state_e exp);
      if (got !== exp)
         stop_on_error($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // store monitor samples before the edge updates anything
   always @(posedge CLK) begin
      if (!rst_n) begin
         hold_pending = 1'b0;
         got_n = 0;
      end else begin
         if (hold_pending) begin
            if (!dcache_write)
               stop_on_error("store request dropped before write_ready went high");
            check_store("dcache_addr", dcache_addr, hold_addr);
            check_store("dcache_data", dcache_data, hold_data);
         end
         hold_pending = dcache_write && !write_ready;
         hold_addr = dcache_addr;
         hold_data = dcache_data;
         if (dcache_write && write_ready) begin
            if (got_n >= exp_addr.size())
               stop_on_error("store accepted that the reference does not produce");
            check_store("dcache_addr", dcache_addr, exp_addr[got_n]);
            check_store("dcache_data", dcache_data, exp_data[got_n]);
            got_n++;
         end
      end
   end

   function automatic logic [31:0] enc(input uop_op_e op, input logic [2:0] dr,
                                       input logic [2:0] sr, input logic [15:0] imm);
      return {op, dr, sr, 6'd0, imm};
   endfunction

   task automatic emit_instr(input uop_op_e op, input logic [2:0] dr,
                             input logic [2:0] sr, input logic [15:0] imm);
      rom[prog_pc] = enc(op, dr, sr, imm);
      prog_pc = prog_pc + 6'd1;
   endtask

   task automatic clear_rom();
      rom = '{default: HALT_WORD};
      prog_pc = 6'd0;
   endtask

   // sequential model of the instruction set
   function automatic core_state_e run_reference();
      logic [31:0] r [8];
      logic        zf;
      logic        cf;
      logic [31:0] pc;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] res;
      logic [32:0] wide;
      logic [2:0]  dr;
      uop_op_e     op;
      int          steps;
      core_state_e st;
      r = '{default: '0};
      zf = 1'b0;
      cf = 1'b0;
      pc = '0;
      steps = 0;
      st = st_run;
      exp_addr.delete();
      exp_data.delete();
      while (st == st_run && steps < 2000) begin
         w = (pc < ROM_DEPTH) ? rom[pc[5:0]] : HALT_WORD;
         op = uop_op_e'(w[OPC_MSB:OPC_LSB]);
         dr = w[DR_MSB:DR_LSB];
         a = r[dr];
         b = r[w[SR_MSB:SR_LSB]];
         imm = {{(32 - IMM_W){w[IMM_W-1]}}, w[IMM_W-1:0]};
         pc = pc + 32'd1;
         steps++;
         case (op)
            op_add, op_sub: begin
               wide = (op == op_add) ? {1'b0, a} + {1'b0, b} : {1'b0, a} - {1'b0, b};
               r[dr] = wide[31:0];
               zf = (wide[31:0] == 32'd0);
               cf = wide[32];
            end
            op_and, op_xor: begin
               res = (op == op_and) ? (a & b) : (a ^ b);
               r[dr] = res;
               zf = (res == 32'd0);
               cf = 1'b0;
            end
            op_movi: r[dr] = imm;
            op_cmovc: begin
               if (cf)
                  r[dr] = b;
            end
            op_jne: begin
               if (!zf)
                  pc = pc + imm;
            end
            op_store: begin
               exp_addr.push_back(a + imm);
               exp_data.push_back(b);
            end
            op_halt: st = st_halted;
            default: ;
         endcase
      end
      return st;
   endfunction

   task automatic fill_ready_pattern();
      logic [31:0] rnd;
      logic        lvl;
      int          idx;
      int          run;
      lvl = 1'b0;
      idx = 0;
      while (idx < 256) begin
         rnd = $random(seed);
         run = 1 + {29'd0, rnd[2:0]};
         while (run > 0 && idx < 256) begin
            ready_pat[idx[7:0]] = lvl;
            idx++;
            run--;
         end
         lvl = !lvl;
      end
   endtask

   task automatic build_arith_program();
      clear_rom();
      emit_instr(op_movi, 3'd1, 3'd0, 16'h1234);
      emit_instr(op_movi, 3'd2, 3'd0, 16'hFFFD);
      emit_instr(op_add, 3'd1, 3'd2, 16'h0000);
      emit_instr(op_store, 3'd0, 3'd1, 16'h0010);
      emit_instr(op_sub, 3'd2, 3'd1, 16'h0000);
      emit_instr(op_store, 3'd0, 3'd2, 16'h0011);
      emit_instr(op_and, 3'd1, 3'd2, 16'h0000);
      emit_instr(op_store, 3'd0, 3'd1, 16'h0012);
      emit_instr(op_xor, 3'd2, 3'd1, 16'h0000);
      emit_instr(op_store, 3'd1, 3'd2, 16'h0004);
      emit_instr(op_movi, 3'd3, 3'd0, 16'h8007);
      emit_instr(op_add, 3'd3, 3'd3, 16'h0000);
      emit_instr(op_add, 3'd3, 3'd3, 16'h0000);
      emit_instr(op_store, 3'd3, 3'd3, 16'hFFFF);
      emit_instr(op_halt, 3'd0, 3'd0, 16'h0000);
      // never retired
      emit_instr(op_store, 3'd0, 3'd1, 16'h0099);
      emit_instr(op_movi, 3'd1, 3'd0, 16'h0BAD);
      emit_instr(op_store, 3'd0, 3'd1, 16'h009A);
   endtask

   task automatic build_cmovc_program();
      clear_rom();
      emit_instr(op_movi, 3'd1, 3'd0, 16'h0005);
      emit_instr(op_movi, 3'd2, 3'd0, 16'h0009);
      emit_instr(op_movi, 3'd4, 3'd0, 16'h0055);
      emit_instr(op_movi, 3'd5, 3'd0, 16'h0077);
      emit_instr(op_sub, 3'd1, 3'd2, 16'h0000);
      emit_instr(op_cmovc, 3'd4, 3'd5, 16'h0000);
      emit_instr(op_store, 3'd0, 3'd4, 16'h0020);
      emit_instr(op_sub, 3'd2, 3'd2, 16'h0000);
      emit_instr(op_cmovc, 3'd5, 3'd1, 16'h0000);
      emit_instr(op_store, 3'd0, 3'd5, 16'h0021);
      emit_instr(op_store, 3'd0, 3'd1, 16'h0022);
      emit_instr(op_halt, 3'd0, 3'd0, 16'h0000);
   endtask

   task automatic build_loop_program();
      clear_rom();
      emit_instr(op_movi, 3'd1, 3'd0, 16'h0004);
      emit_instr(op_movi, 3'd2, 3'd0, 16'h0001);
      emit_instr(op_movi, 3'd6, 3'd0, 16'h0100);
      emit_instr(op_store, 3'd6, 3'd1, 16'h0000);
      emit_instr(op_add, 3'd6, 3'd2, 16'h0000);
      emit_instr(op_sub, 3'd1, 3'd2, 16'h0000);
      // back to the store at slot 3
      emit_instr(op_jne, 3'd0, 3'd0, 16'hFFFC);
      emit_instr(op_store, 3'd0, 3'd1, 16'h0030);
      emit_instr(op_halt, 3'd0, 3'd0, 16'h0000);
      emit_instr(op_store, 3'd0, 3'd2, 16'h0031);
   endtask

   // only forward jumps so every program reaches its halt
   task automatic build_random_program();
      logic [31:0] rnd;
      uop_op_e     op;
      logic [15:0] imm;
      int          len;
      int          k;
      clear_rom();
      len = 40;
      for (int i = 0; i < len; i++) begin
         rnd = $random(seed);
         case (rnd[31:29])
            3'd0: op = op_add;
            3'd1: op = op_sub;
            3'd2: op = op_and;
            3'd3: op = op_xor;
            3'd4: op = op_movi;
            3'd5: op = op_cmovc;
            3'd6: op = op_store;
            default: op = op_jne;
         endcase
         imm = rnd[15:0];
         if (op == op_jne) begin
            k = {30'd0, rnd[9:8]};
            if (i + 1 + k > len)
               k = len - 1 - i;
            imm = k[15:0];
         end
         emit_instr(op, rnd[27:25], rnd[24:22], imm);
      end
      emit_instr(op_halt, 3'd0, 3'd0, 16'h0000);
      emit_instr(op_store, 3'd0, 3'd0, 16'h00EE);
   endtask

   task automatic run_program(input string name, input logic stalls);
      core_state_e exp_state;
      int          cyc;
      logic [31:0] frozen_eip;
      @(posedge CLK);
      rst_n <= 1'b0;
      @(negedge CLK);
      bp_mode = stalls;
      exp_state = run_reference();
      repeat (5) @(posedge CLK);
      rst_n <= 1'b1;
      cyc = 0;
      while (!halted && cyc < TIMEOUT) begin
         @(negedge CLK);
         cyc++;
      end
      if (!halted)
         stop_on_error($sformatf("%s: timed out waiting for halted", name));
      frozen_eip = fetch_eip;
      // halted and fetch_eip hold and nothing behind the halt retires
      repeat (10) begin
         @(negedge CLK);
         check_state("halted", core_state_e'(halted), exp_state);
         check_store("fetch_eip", fetch_eip, frozen_eip);
      end
      if (got_n != exp_addr.size())
         stop_on_error($sformatf("%s: %0d stores seen but %0d expected",
                                 name, got_n, exp_addr.size()));
      $display("%s: %0d stores matched", name, got_n);
   endtask

   initial begin
      rst_n = 1'b0;
      seed = 32'h73ed6d6b;
      fill_ready_pattern();
      build_arith_program();
      run_program("arith chain", 1'b0);
      build_cmovc_program();
      run_program("cmovc", 1'b0);
      build_loop_program();
      run_program("jne loop", 1'b0);
      run_program("jne loop with back-pressure", 1'b1);
      build_arith_program();
      run_program("arith chain with back-pressure", 1'b1);
      for (int n = 0; n < 6; n++) begin
         build_random_program();
         run_program($sformatf("random program %0d", n), n[0]);
      end
      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- uop_core.sv
`timescale 1ns/100ps
`default_nettype none

module uop_core import uop_pkg::*; #(
   parameter logic [31:0] RESET_EIP = 32'h0000_0000
) (
   input  wire         CLK,
   input  wire         rst_n,
   output logic [31:0] fetch_eip,
   input  wire  [31:0] instr,
   output logic        dcache_write,
   output logic [31:0] dcache_addr,
   output logic [31:0] dcache_data,
   input  wire         write_ready,
   output logic        halted
);

   // state block
   logic [2:0]  gpr_ra;
   logic [2:0]  gpr_rb;
   logic [31:0] rd_a;
   logic [31:0] rd_b;
   logic        gpr_ld;
   logic [2:0]  gpr_dr;
   logic [31:0] gpr_data;
   logic        flags_ld;
   logic [1:0]  flags_data;
   logic [1:0]  cur_flags;
   logic        eip_ld;
   logic [31:0] eip_data;
   logic        halt_ld;
   logic        fetch_hold;

   // decode to execute
   logic        ex_v;
   uop_op_e     ex_op;
   logic [2:0]  ex_dr;
   logic [31:0] ex_a;
   logic [31:0] ex_b;
   logic [31:0] ex_imm;
   logic [31:0] ex_eip;
   logic        dep_ex_v_gpr;
   logic [2:0]  dep_ex_dr;
   logic        dep_ex_flags;

   // execute to writeback
   logic        wb_v_in;
   uop_op_e     wb_op_in;
   logic [2:0]  wb_dr_in;
   logic [31:0] wb_result_in;
   logic [1:0]  wb_flags_in;
   logic        wb_ld_flags_in;
   logic [31:0] wb_target_in;
   logic [31:0] wb_store_data_in;
   logic        wb_stall;
   logic        flush;
   logic        dep_v_gpr;
   logic [2:0]  dep_dr;
   logic        dep_wb_flags;

   // fetch_hold already folds in wb_stall
   arch_state #(
      .RESET_EIP (RESET_EIP)
   ) arch_state_inst (
      .*,
      .stall (fetch_hold)
   );

   uop_decode uop_decode_inst (.*);

   uop_execute uop_execute_inst (.*);

   writeback writeback_inst (.*);

endmodule

`default_nettype wire

//--- uop_decode.sv
`timescale 1ns/100ps
`default_nettype none

module uop_decode import uop_pkg::*; (
   input  wire         CLK,
   input  wire         rst_n,
   input  wire  [31:0] instr,
   input  wire  [31:0] fetch_eip,
   input  wire         halted,
   output logic        fetch_hold,
   output logic [2:0]  gpr_ra,
   output logic [2:0]  gpr_rb,
   input  wire  [31:0] rd_a,
   input  wire  [31:0] rd_b,
   input  wire         dep_ex_v_gpr,
   input  wire  [2:0]  dep_ex_dr,
   input  wire         dep_ex_flags,
   input  wire         dep_v_gpr,
   input  wire  [2:0]  dep_dr,
   input  wire         dep_wb_flags,
   input  wire         wb_stall,
   input  wire         flush,
   output logic        ex_v,
   output uop_op_e     ex_op,
   output logic [2:0]  ex_dr,
   output logic [31:0] ex_a,
   output logic [31:0] ex_b,
   output logic [31:0] ex_imm,
   output logic [31:0] ex_eip
);

   logic        f_v;
   logic [31:0] f_instr;
   logic [31:0] f_eip;
   uop_op_e     op;
   logic        uses_a;
   logic        uses_b;
   logic        uses_flags;
   logic        raw_ex;
   logic        raw_wb;
   logic        hazard;

   // fetch register
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n)
         f_v <= 1'b0;
      else if (flush)
         f_v <= 1'b0;
      else if (!fetch_hold)
         f_v <= !halted;
   end

   always_ff @(posedge CLK) begin
      if (!fetch_hold) begin
         f_instr <= instr;
         f_eip   <= fetch_eip;
      end
   end

   // field split
   assign op     = uop_op_e'(f_instr[OPC_MSB:OPC_LSB]);
   assign gpr_ra = f_instr[DR_MSB:DR_LSB];
   assign gpr_rb = f_instr[SR_MSB:SR_LSB];

   always_comb begin
      uses_a     = 1'b0;
      uses_b     = 1'b0;
      uses_flags = 1'b0;
      case (op)
         op_add, op_sub, op_and, op_xor, op_store: begin
            uses_a = 1'b1;
            uses_b = 1'b1;
         end
         op_cmovc: begin
            uses_b     = 1'b1;
            uses_flags = 1'b1;
         end
         op_jne:
            uses_flags = 1'b1;
         default: ;
      endcase
   end

   // read-after-write against execute and writeback
   assign raw_ex = dep_ex_v_gpr &&
                   ((uses_a && dep_ex_dr == gpr_ra) || (uses_b && dep_ex_dr == gpr_rb));
   assign raw_wb = dep_v_gpr &&
                   ((uses_a && dep_dr == gpr_ra) || (uses_b && dep_dr == gpr_rb));
   assign hazard = f_v && (raw_ex || raw_wb || (uses_flags && (dep_ex_flags || dep_wb_flags)));

   assign fetch_hold = hazard || wb_stall;

   // bubble while held
   assign ex_v   = f_v && !hazard;
   assign ex_op  = op;
   assign ex_dr  = gpr_ra;
   assign ex_a   = rd_a;
   assign ex_b   = rd_b;
   assign ex_imm = {{(32 - IMM_W){f_instr[IMM_W-1]}}, f_instr[IMM_W-1:0]};
   assign ex_eip = f_eip;

endmodule

`default_nettype wire

//--- uop_execute.sv
`timescale 1ns/100ps
`default_nettype none

module uop_execute import uop_pkg::*; (
   input  wire          CLK,
   input  wire          rst_n,
   input  wire          ex_v,
   input  wire uop_op_e ex_op,
   input  wire  [2:0]   ex_dr,
   input  wire  [31:0]  ex_a,
   input  wire  [31:0]  ex_b,
   input  wire  [31:0]  ex_imm,
   input  wire  [31:0]  ex_eip,
   input  wire          wb_stall,
   input  wire          flush,
   output logic         dep_ex_v_gpr,
   output logic [2:0]   dep_ex_dr,
   output logic         dep_ex_flags,
   output logic         wb_v_in,
   output uop_op_e      wb_op_in,
   output logic [2:0]   wb_dr_in,
   output logic [31:0]  wb_result_in,
   output logic [1:0]   wb_flags_in,
   output logic         wb_ld_flags_in,
   output logic [31:0]  wb_target_in,
   output logic [31:0]  wb_store_data_in
);

   logic        v_q;
   uop_op_e     op_q;
   logic [2:0]  dr_q;
   logic [31:0] a_q;
   logic [31:0] b_q;
   logic [31:0] imm_q;
   logic [31:0] eip_q;
   logic [32:0] sum;
   logic [32:0] diff;
   logic [31:0] result;
   logic        carry;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n)
         v_q <= 1'b0;
      else if (flush)
         v_q <= 1'b0;
      else if (!wb_stall)
         v_q <= ex_v;
   end

   always_ff @(posedge CLK) begin
      if (!wb_stall) begin
         op_q  <= ex_op;
         dr_q  <= ex_dr;
         a_q   <= ex_a;
         b_q   <= ex_b;
         imm_q <= ex_imm;
         eip_q <= ex_eip;
      end
   end

   assign sum  = {1'b0, a_q} + {1'b0, b_q};
   // top bit is the borrow
   assign diff = {1'b0, a_q} - {1'b0, b_q};

   always_comb begin
      result = '0;
      carry  = 1'b0;
      case (op_q)
         op_add: begin
            result = sum[31:0];
            carry  = sum[32];
         end
         op_sub: begin
            result = diff[31:0];
            carry  = diff[32];
         end
         op_and:   result = a_q & b_q;
         op_xor:   result = a_q ^ b_q;
         op_movi:  result = imm_q;
         op_cmovc: result = b_q;
         // store address
         op_store: result = a_q + imm_q;
         default:  result = '0;
      endcase
   end

   always_comb begin
      wb_flags_in          = '0;
      wb_flags_in[FLAG_ZF] = (result == '0);
      wb_flags_in[FLAG_CF] = carry;
   end

   assign wb_v_in          = v_q;
   assign wb_op_in         = op_q;
   assign wb_dr_in         = dr_q;
   assign wb_result_in     = result;
   assign wb_ld_flags_in   = op_writes_flags(op_q);
   assign wb_target_in     = eip_q + 32'd1 + imm_q;
   assign wb_store_data_in = b_q;

   // in-flight marks for decode
   assign dep_ex_v_gpr = v_q && op_writes_gpr(op_q);
   assign dep_ex_dr    = dr_q;
   assign dep_ex_flags = v_q && op_writes_flags(op_q);

endmodule

`default_nettype wire

//--- uop_pkg.sv
`default_nettype none

package uop_pkg;

   // opcode field values
   typedef enum logic [3:0] {
      op_nop   = 4'h0,
      op_add   = 4'h1,
      op_sub   = 4'h2,
      op_and   = 4'h3,
      op_xor   = 4'h4,
      op_movi  = 4'h5,
      op_cmovc = 4'h6,
      op_jne   = 4'h7,
      op_store = 4'h8,
      op_halt  = 4'h9
   } uop_op_e;

   typedef enum logic {
      st_run    = 1'b0,
      st_halted = 1'b1
   } core_state_e;

   // instruction word fields
   localparam int OPC_MSB = 31;
   localparam int OPC_LSB = 28;
   localparam int DR_MSB  = 27;
   localparam int DR_LSB  = 25;
   localparam int SR_MSB  = 24;
   localparam int SR_LSB  = 22;
   localparam int IMM_W   = 16;

   // bits of the flags vector
   localparam int FLAG_ZF = 0;
   localparam int FLAG_CF = 1;

   // ops that may load a general register
   function automatic logic op_writes_gpr(uop_op_e op);
      case (op)
         op_add, op_sub, op_and, op_xor, op_movi, op_cmovc:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

   function automatic logic op_writes_flags(uop_op_e op);
      case (op)
         op_add, op_sub, op_and, op_xor:
            return 1'b1;
         default:
            return 1'b0;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- writeback.sv
`timescale 1ns/100ps
`default_nettype none

module writeback import uop_pkg::*; (
   input  wire          CLK,
   input  wire          rst_n,
   input  wire          wb_v_in,
   input  wire uop_op_e wb_op_in,
   input  wire  [2:0]   wb_dr_in,
   input  wire  [31:0]  wb_result_in,
   input  wire  [1:0]   wb_flags_in,
   input  wire          wb_ld_flags_in,
   input  wire  [31:0]  wb_target_in,
   input  wire  [31:0]  wb_store_data_in,
   input  wire  [1:0]   cur_flags,
   input  wire          write_ready,
   output logic         gpr_ld,
   output logic [2:0]   gpr_dr,
   output logic [31:0]  gpr_data,
   output logic         flags_ld,
   output logic [1:0]   flags_data,
   output logic         eip_ld,
   output logic [31:0]  eip_data,
   output logic         halt_ld,
   output logic         dcache_write,
   output logic [31:0]  dcache_addr,
   output logic [31:0]  dcache_data,
   output logic         wb_stall,
   output logic         flush,
   output logic         dep_v_gpr,
   output logic [2:0]   dep_dr,
   output logic         dep_wb_flags
);

   logic        v_q;
   uop_op_e     op_q;
   logic [2:0]  dr_q;
   logic [31:0] result_q;
   logic [1:0]  flags_q;
   logic        ld_flags_q;
   logic [31:0] target_q;
   logic [31:0] store_data_q;
   logic        ld_gpr;
   logic        taken;
   logic        go;

   // the op entering on a flush edge is younger than the flusher
   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n)
         v_q <= 1'b0;
      else if (!wb_stall)
         v_q <= wb_v_in && !flush;
   end

   always_ff @(posedge CLK) begin
      if (!wb_stall) begin
         op_q         <= wb_op_in;
         dr_q         <= wb_dr_in;
         result_q     <= wb_result_in;
         flags_q      <= wb_flags_in;
         ld_flags_q   <= wb_ld_flags_in;
         target_q     <= wb_target_in;
         store_data_q <= wb_store_data_in;
      end
   end

   // cmovc and jne resolve on committed flags
   always_comb begin
      ld_gpr = op_writes_gpr(op_q);
      if (op_q == op_cmovc)
         ld_gpr = cur_flags[FLAG_CF];
   end

   assign taken = (op_q == op_jne) && !cur_flags[FLAG_ZF];

   // store held until write_ready
   assign dcache_write = v_q && (op_q == op_store);
   assign dcache_addr  = result_q;
   assign dcache_data  = store_data_q;
   assign wb_stall     = dcache_write && !write_ready;

   assign go = v_q && !wb_stall;

   assign gpr_ld     = go && ld_gpr;
   assign gpr_dr     = dr_q;
   assign gpr_data   = result_q;
   assign flags_ld   = go && ld_flags_q;
   assign flags_data = flags_q;
   assign eip_ld     = go && taken;
   assign eip_data   = target_q;
   assign halt_ld    = go && (op_q == op_halt);
   assign flush      = eip_ld || halt_ld;

   assign dep_v_gpr    = v_q && op_writes_gpr(op_q);
   assign dep_dr       = dr_q;
   assign dep_wb_flags = v_q && ld_flags_q;

endmodule

`default_nettype wire
